/* hw/rename_pkg.sv */
// Rename unit shared sizes and types
`default_nettype none

package rename_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int DISP_SIZE     = 2;   // instructions per dispatch group
  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 64;

  // free physical regs split evenly over the slots
  localparam int FLIST_DEPTH = (NUM_PHYS_REGS - NUM_ARCH_REGS) / DISP_SIZE;

  // ----------------------------------------------------------
  // vector types
  // ----------------------------------------------------------
  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;   // x0..x31
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0] rnid_t;       // physical reg id
  typedef logic [DISP_SIZE-1:0]             grp_t;        // one bit per slot
  typedef logic [$clog2(FLIST_DEPTH)-1:0]   flist_ptr_t;

endpackage

`default_nettype wire

/* hw/rename_group_if.sv */
// Dispatch group bundle
`timescale 1ns/1ps
`default_nettype none

interface rename_group_if;
  import rename_pkg::*;

  logic      fire;                   // group accepted this edge
  grp_t      slot_valid;
  grp_t      rd_valid;
  arch_reg_t rd_arch  [DISP_SIZE];
  arch_reg_t rs1_arch [DISP_SIZE];
  arch_reg_t rs2_arch [DISP_SIZE];

  // consumers only read the group
  modport sink (
    input fire,
    input slot_valid,
    input rd_valid,
    input rd_arch,
    input rs1_arch,
    input rs2_arch
  );

endinterface

`default_nettype wire

/* hw/rename_freelist.sv */
// Per-slot free list of physical IDs
`timescale 1ns/1ps
`default_nettype none

module rename_freelist #(
  parameter int SLOT = 0
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  rename_group_if.sink      grp,
  input  logic              i_push,
  input  rename_pkg::rnid_t i_push_rnid,
  output rename_pkg::rnid_t o_new_rnid,
  output logic              o_empty
);
  import rename_pkg::*;

  rnid_t                        r_fifo [FLIST_DEPTH];
  flist_ptr_t                   r_rd_ptr;
  flist_ptr_t                   r_wr_ptr;
  logic [$clog2(FLIST_DEPTH):0] r_count;   // 0..FLIST_DEPTH
  logic                         w_rd_x0;
  logic                         w_pop;

  // ------------------------------------------------------------
  // pop condition
  // ------------------------------------------------------------
  assign w_rd_x0 = (grp.rd_arch[SLOT] == '0);
  assign w_pop   = grp.fire & grp.slot_valid[SLOT] & grp.rd_valid[SLOT] & ~w_rd_x0;

  // ------------------------------------------------------------
  // storage, starts full of this slot's id range
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < FLIST_DEPTH; i++) begin
        r_fifo[i] <= rnid_t'(NUM_ARCH_REGS + FLIST_DEPTH * SLOT + i);
      end
    end else if (i_push) begin
      r_fifo[r_wr_ptr] <= i_push_rnid;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_ptr <= '0;
      r_wr_ptr <= '0;   // full, so write side sits on the read side
      r_count  <= FLIST_DEPTH[$clog2(FLIST_DEPTH):0];
    end else begin
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;   // wraps at FLIST_DEPTH
      end
      if (i_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      case ({i_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;   // none, or push and pop together
      endcase
    end
  end

  // x0 destination never takes a register
  assign o_new_rnid = w_rd_x0 ? '0 : r_fifo[r_rd_ptr];
  assign o_empty    = (r_count == '0);

endmodule

`default_nettype wire

/* hw/rename_commit_release.sv */
// Commit release to the free lists
`timescale 1ns/1ps
`default_nettype none

module rename_commit_release (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_cmt_valid,
  input  rename_pkg::grp_t  i_cmt_slot_valid,
  input  rename_pkg::grp_t  i_cmt_dead,
  input  rename_pkg::rnid_t i_cmt_rnid     [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t i_cmt_old_rnid [rename_pkg::DISP_SIZE],
  output rename_pkg::grp_t  o_push,
  output rename_pkg::rnid_t o_push_rnid    [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  rnid_t w_ret_rnid [DISP_SIZE];
  grp_t  w_push;
  grp_t  r_push;
  rnid_t r_push_rnid [DISP_SIZE];

  // dead inst gives back its new id, a normal commit the old one
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_ret
    assign w_ret_rnid[d] = i_cmt_dead[d] ? i_cmt_rnid[d] : i_cmt_old_rnid[d];
    assign w_push[d]     = i_cmt_valid & i_cmt_slot_valid[d] & (w_ret_rnid[d] != '0);
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_push <= '0;
    end else begin
      r_push <= w_push;
    end
  end

  always_ff @(posedge i_clk) begin
    r_push_rnid <= w_ret_rnid;   // id handed back per slot
  end

  assign o_push      = r_push;
  assign o_push_rnid = r_push_rnid;

endmodule

`default_nettype wire

/* hw/rename_map_table.sv */
// Architectural to physical map table
`timescale 1ns/1ps
`default_nettype none

module rename_map_table (
  input  logic              i_clk,
  input  logic              i_reset_n,
  rename_group_if.sink      grp,
  input  rename_pkg::rnid_t i_new_rnid    [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rs1_rnid    [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rs2_rnid    [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rd_old_rnid [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  rnid_t r_map [NUM_ARCH_REGS];
  grp_t  w_wr;

  // ------------------------------------------------------------
  // update on accepted group
  // ------------------------------------------------------------
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_wr
    assign w_wr[d] = grp.fire & grp.slot_valid[d] & grp.rd_valid[d] &
                     (grp.rd_arch[d] != '0);   // x0 stays at id 0
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        r_map[i] <= rnid_t'(i);   // identity map
      end
    end else begin
      // ascending slot order, younger slot wins on same rd
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_wr[d]) begin
          r_map[grp.rd_arch[d]] <= i_new_rnid[d];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // lookups
  // ------------------------------------------------------------
  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_rd
    assign o_rs1_rnid[d]    = r_map[grp.rs1_arch[d]];
    assign o_rs2_rnid[d]    = r_map[grp.rs2_arch[d]];
    assign o_rd_old_rnid[d] = r_map[grp.rd_arch[d]];
  end

endmodule

`default_nettype wire

/* hw/rename_group_bypass.sv */
// In-group dependency forwarding
`timescale 1ns/1ps
`default_nettype none

module rename_group_bypass (
  rename_group_if.sink      grp,
  input  rename_pkg::rnid_t i_new_rnid        [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t i_map_rs1_rnid    [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t i_map_rs2_rnid    [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t i_map_rd_old_rnid [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rs1_rnid        [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rs2_rnid        [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rd_old_rnid     [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t o_rd_rnid         [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  grp_t w_writes;   // slot allocates a real destination

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_wr
    assign w_writes[d] = grp.slot_valid[d] & grp.rd_valid[d] & (grp.rd_arch[d] != '0);
  end

  // start from the map, let each older writer in the group override;
  // the nearest older writer is applied last
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rs1_rnid[d]    = i_map_rs1_rnid[d];
      o_rs2_rnid[d]    = i_map_rs2_rnid[d];
      o_rd_old_rnid[d] = i_map_rd_old_rnid[d];
      for (int p = 0; p < d; p++) begin
        if (w_writes[p] && (grp.rd_arch[p] == grp.rs1_arch[d])) begin
          o_rs1_rnid[d] = i_new_rnid[p];
        end
        if (w_writes[p] && (grp.rd_arch[p] == grp.rs2_arch[d])) begin
          o_rs2_rnid[d] = i_new_rnid[p];
        end
        if (w_writes[p] && (grp.rd_arch[p] == grp.rd_arch[d])) begin
          o_rd_old_rnid[d] = i_new_rnid[p];   // old id is the older slot's new one
        end
      end
    end
  end

  assign o_rd_rnid = i_new_rnid;   // freelist head, 0 for x0

endmodule

`default_nettype wire

/* hw/rename_unit.sv */
// Register rename unit, integer file
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // dispatch group
  input  logic                  i_front_valid,
  output logic                  o_ready,
  input  rename_pkg::grp_t      i_slot_valid,
  input  rename_pkg::grp_t      i_rd_valid,
  input  rename_pkg::arch_reg_t i_rd_arch      [rename_pkg::DISP_SIZE],
  input  rename_pkg::arch_reg_t i_rs1_arch     [rename_pkg::DISP_SIZE],
  input  rename_pkg::arch_reg_t i_rs2_arch     [rename_pkg::DISP_SIZE],
  // commit, always accepted
  input  logic                  i_cmt_valid,
  input  rename_pkg::grp_t      i_cmt_slot_valid,
  input  rename_pkg::grp_t      i_cmt_dead,
  input  rename_pkg::rnid_t     i_cmt_rnid     [rename_pkg::DISP_SIZE],
  input  rename_pkg::rnid_t     i_cmt_old_rnid [rename_pkg::DISP_SIZE],
  // results
  output rename_pkg::rnid_t     o_rd_rnid      [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t     o_rd_old_rnid  [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t     o_rs1_rnid     [rename_pkg::DISP_SIZE],
  output rename_pkg::rnid_t     o_rs2_rnid     [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  rename_group_if grp_if ();

  grp_t  w_empty;
  grp_t  w_push;
  rnid_t w_push_rnid   [DISP_SIZE];
  rnid_t w_new_rnid    [DISP_SIZE];
  rnid_t w_map_rs1     [DISP_SIZE];
  rnid_t w_map_rs2     [DISP_SIZE];
  rnid_t w_map_rd_old  [DISP_SIZE];

  // ------------------------------------------------------------
  // handshake and group bundle
  // ------------------------------------------------------------
  assign o_ready           = ~(|w_empty);   // stall if any list ran dry
  assign grp_if.fire       = i_front_valid & o_ready;
  assign grp_if.slot_valid = i_slot_valid;
  assign grp_if.rd_valid   = i_rd_valid;
  assign grp_if.rd_arch    = i_rd_arch;
  assign grp_if.rs1_arch   = i_rs1_arch;
  assign grp_if.rs2_arch   = i_rs2_arch;

  // ------------------------------------------------------------
  // free lists and commit return
  // ------------------------------------------------------------
  for (genvar s = 0; s < DISP_SIZE; s++) begin : g_flist
    rename_freelist #(.SLOT(s)) u_freelist (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .grp         (grp_if),
      .i_push      (w_push[s]),
      .i_push_rnid (w_push_rnid[s]),
      .o_new_rnid  (w_new_rnid[s]),
      .o_empty     (w_empty[s])
    );
  end

  rename_commit_release u_commit_release (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_cmt_valid      (i_cmt_valid),
    .i_cmt_slot_valid (i_cmt_slot_valid),
    .i_cmt_dead       (i_cmt_dead),
    .i_cmt_rnid       (i_cmt_rnid),
    .i_cmt_old_rnid   (i_cmt_old_rnid),
    .o_push           (w_push),
    .o_push_rnid      (w_push_rnid)
  );

  rename_map_table u_map_table (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .grp           (grp_if),
    .i_new_rnid    (w_new_rnid),
    .o_rs1_rnid    (w_map_rs1),
    .o_rs2_rnid    (w_map_rs2),
    .o_rd_old_rnid (w_map_rd_old)
  );

  rename_group_bypass u_group_bypass (
    .grp               (grp_if),
    .i_new_rnid        (w_new_rnid),
    .i_map_rs1_rnid    (w_map_rs1),
    .i_map_rs2_rnid    (w_map_rs2),
    .i_map_rd_old_rnid (w_map_rd_old),
    .o_rs1_rnid        (o_rs1_rnid),
    .o_rs2_rnid        (o_rs2_rnid),
    .o_rd_old_rnid     (o_rd_old_rnid),
    .o_rd_rnid         (o_rd_rnid)
  );

endmodule

`default_nettype wire

/* tb/rename_unit_sva.sv */
// Rename unit port assertions
`timescale 1ns/1ps
`default_nettype none

module rename_unit_sva (
  input logic                  i_clk,
  input logic                  i_reset_n,
  input logic                  i_front_valid,
  input logic                  o_ready,
  input rename_pkg::grp_t      i_slot_valid,
  input rename_pkg::grp_t      i_rd_valid,
  input rename_pkg::arch_reg_t i_rd_arch [rename_pkg::DISP_SIZE],
  input rename_pkg::rnid_t     o_rd_rnid [rename_pkg::DISP_SIZE]
);
  import rename_pkg::*;

  grp_t w_alloc;   // slot takes a free id this edge

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_alloc
    assign w_alloc[d] = i_front_valid & o_ready & i_slot_valid[d] & i_rd_valid[d] &
                        (i_rd_arch[d] != '0);

    a_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_alloc[d] |-> (o_rd_rnid[d] != '0))
      else $error("real destination renamed to id 0");
  end

  a_ready_after_reset: assert property (@(posedge i_clk) $rose(i_reset_n) |-> o_ready)
    else $error("o_ready low right after reset");

  a_distinct_ids: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_alloc == 2'b11) |-> (o_rd_rnid[0] != o_rd_rnid[1]))
    else $error("both slots got the same new id");

endmodule

bind rename_unit rename_unit_sva u_sva (.*);

`default_nettype wire

/* tb/tb_rename_unit.sv */
// Rename unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;
  import rename_pkg::*;

  localparam int N_RAND     = 400;
  localparam int N_GROUPS   = N_RAND + 50;           // directed groups included
  localparam int MAX_CYCLES = N_GROUPS * 4 + 200;

  logic      i_clk;
  logic      i_reset_n;
  logic      i_front_valid;
  logic      o_ready;
  grp_t      i_slot_valid;
  grp_t      i_rd_valid;
  arch_reg_t i_rd_arch [DISP_SIZE];
  arch_reg_t i_rs1_arch [DISP_SIZE];
  arch_reg_t i_rs2_arch [DISP_SIZE];
  logic      i_cmt_valid;
  grp_t      i_cmt_slot_valid;
  grp_t      i_cmt_dead;
  rnid_t     i_cmt_rnid [DISP_SIZE];
  rnid_t     i_cmt_old_rnid [DISP_SIZE];
  rnid_t     o_rd_rnid [DISP_SIZE];
  rnid_t     o_rd_old_rnid [DISP_SIZE];
  rnid_t     o_rs1_rnid [DISP_SIZE];
  rnid_t     o_rs2_rnid [DISP_SIZE];

  // reference model state
  rnid_t m_map [NUM_ARCH_REGS];
  rnid_t fl_q [DISP_SIZE][$];
  grp_t  pend_push;                // commit waiting one cycle
  rnid_t pend_id [DISP_SIZE];
  rnid_t exp_rd [DISP_SIZE];
  rnid_t exp_old [DISP_SIZE];
  rnid_t exp_rs1 [DISP_SIZE];
  rnid_t exp_rs2 [DISP_SIZE];
  grp_t  exp_wr;
  logic  exp_ready;
  logic  exp_fire;
  logic  last_fire;
  int    alloc_cnt [DISP_SIZE];

  // renamed, not yet committed, in program order
  int    cq_slot [$];
  rnid_t cq_new [$];
  rnid_t cq_old [$];

  logic [31:0] stim_seed;
  logic [31:0] cmt_seed;
  int          cmt_credit;
  logic        cmt_rand_en;
  int          cycles;

  rename_unit rename_unit_i (.*);

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function void rename_model();
    for (int d = 0; d < DISP_SIZE; d++) begin
      exp_wr[d]  = i_slot_valid[d] & i_rd_valid[d] & (i_rd_arch[d] != '0);
      exp_rd[d]  = (i_rd_arch[d] == '0 || fl_q[d].size() == 0) ? '0 : fl_q[d][0];
      exp_rs1[d] = m_map[i_rs1_arch[d]];
      exp_rs2[d] = m_map[i_rs2_arch[d]];
      exp_old[d] = m_map[i_rd_arch[d]];
    end
    if (exp_wr[0]) begin   // slot 1 sees slot 0's new id
      if (i_rd_arch[0] == i_rs1_arch[1]) exp_rs1[1] = exp_rd[0];
      if (i_rd_arch[0] == i_rs2_arch[1]) exp_rs2[1] = exp_rd[0];
      if (i_rd_arch[0] == i_rd_arch[1])  exp_old[1] = exp_rd[0];
    end
    exp_ready = (fl_q[0].size() != 0) && (fl_q[1].size() != 0);
    exp_fire  = i_front_valid && exp_ready;
  endfunction

  task automatic advance_model();
    rnid_t ret;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (exp_fire && exp_wr[d]) begin
        void'(fl_q[d].pop_front());
        cq_slot.push_back(d);
        cq_new.push_back(exp_rd[d]);
        cq_old.push_back(exp_old[d]);
        alloc_cnt[d]++;
        m_map[i_rd_arch[d]] = exp_rd[d];   // slot 1 written last
      end
      if (pend_push[d]) fl_q[d].push_back(pend_id[d]);
      ret          = i_cmt_dead[d] ? i_cmt_rnid[d] : i_cmt_old_rnid[d];
      pend_push[d] = i_cmt_valid & i_cmt_slot_valid[d] & (ret != '0);
      pend_id[d]   = ret;
    end
    last_fire = exp_fire;
  endtask

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_rnid(input rnid_t act, input rnid_t exp, input string what);
    if (act !== exp) begin
      $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, act, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_ready(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("** Error at time %0t: %s is %b, expected %b", $time, what, act, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      rename_model();
      check_ready(o_ready, exp_ready, "o_ready");
      if (i_front_valid && exp_ready) begin
        for (int d = 0; d < DISP_SIZE; d++) begin
          check_rnid(o_rd_rnid[d], exp_rd[d], $sformatf("o_rd_rnid[%0d]", d));
          check_rnid(o_rd_old_rnid[d], exp_old[d], $sformatf("o_rd_old_rnid[%0d]", d));
          check_rnid(o_rs1_rnid[d], exp_rs1[d], $sformatf("o_rs1_rnid[%0d]", d));
          check_rnid(o_rs2_rnid[d], exp_rs2[d], $sformatf("o_rs2_rnid[%0d]", d));
        end
      end
      advance_model();
    end
  end

  // ------------------------------------------------------------
  // commit driver, oldest first
  // ------------------------------------------------------------
  always @(posedge i_clk) begin
    logic [31:0] r;
    int          s;
    logic        dead;
    #2;
    i_cmt_valid      = 1'b0;
    i_cmt_slot_valid = '0;
    i_cmt_dead       = '0;
    cmt_seed = lcg_step(cmt_seed);
    r        = cmt_seed;
    if (i_reset_n && cq_new.size() > 0 &&
        (cmt_credit > 0 || (cmt_rand_en && r[17:16] != 2'b00))) begin
      if (cmt_credit > 0) cmt_credit--;
      s    = cq_slot[0];
      dead = 1'b0;
      // dead only if a younger inst took over the id, which then frees our old one
      if (cmt_rand_en && r[21:20] == 2'b00) begin
        for (int j = 1; j < cq_new.size(); j++) begin
          if (!dead && cq_old[j] == cq_new[0]) begin
            cq_old[j] = cq_old[0];
            dead      = 1'b1;
          end
        end
      end
      i_cmt_valid       = 1'b1;
      i_cmt_slot_valid  = grp_t'(1 << s);
      i_cmt_dead        = dead ? grp_t'(1 << s) : '0;
      i_cmt_rnid[s]     = cq_new[0];
      i_cmt_old_rnid[s] = cq_old[0];
      void'(cq_slot.pop_front());
      void'(cq_new.pop_front());
      void'(cq_old.pop_front());
    end
  end

  // ------------------------------------------------------------
  // group stimulus
  // ------------------------------------------------------------
  task automatic set_group(input grp_t sv, input grp_t rdv, input int rd0, input int rs10,
                           input int rs20, input int rd1, input int rs11, input int rs21);
    i_front_valid = 1'b1;
    i_slot_valid  = sv;
    i_rd_valid    = rdv;
    i_rd_arch[0]  = arch_reg_t'(rd0);
    i_rs1_arch[0] = arch_reg_t'(rs10);
    i_rs2_arch[0] = arch_reg_t'(rs20);
    i_rd_arch[1]  = arch_reg_t'(rd1);
    i_rs1_arch[1] = arch_reg_t'(rs11);
    i_rs2_arch[1] = arch_reg_t'(rs21);
  endtask

  task automatic wait_accept();
    @(posedge i_clk);
    while (!last_fire) @(posedge i_clk);
    #2;
    i_front_valid = 1'b0;
  endtask

  task automatic send_group(input grp_t sv, input grp_t rdv, input int rd0, input int rs10,
                            input int rs20, input int rd1, input int rs11, input int rs21);
    set_group(sv, rdv, rd0, rs10, rs20, rd1, rs11, rs21);
    wait_accept();
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

  initial begin
    logic [31:0] r;
    int          k;
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_front_valid = 1'b0;
    i_slot_valid = '0;
    i_rd_valid = '0;
    i_cmt_valid = 1'b0;
    i_cmt_slot_valid = '0;
    i_cmt_dead = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_rd_arch[d] = '0;
      i_rs1_arch[d] = '0;
      i_rs2_arch[d] = '0;
      i_cmt_rnid[d] = '0;
      i_cmt_old_rnid[d] = '0;
      pend_id[d] = '0;
      alloc_cnt[d] = 0;
      for (int i = 0; i < FLIST_DEPTH; i++) begin
        fl_q[d].push_back(rnid_t'(NUM_ARCH_REGS + FLIST_DEPTH * d + i));
      end
    end
    for (int i = 0; i < NUM_ARCH_REGS; i++) m_map[i] = rnid_t'(i);
    pend_push = '0;
    last_fire = 1'b0;
    stim_seed = 32'h5ceb_5c0a;
    cmt_seed = lcg_step(32'h5ceb_5c0a);
    cmt_credit = 0;
    cmt_rand_en = 1'b0;
    cycles = 0;

    repeat (4) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;

    // reset map, nothing written
    for (k = 0; k < 16; k++) begin
      send_group(2'b00, 2'b00, k, 2 * k, 2 * k + 1, 31 - k, 31 - 2 * k, 30 - 2 * k);
    end

    // allocation order, x0 destination
    send_group(2'b11, 2'b11, 1, 0, 0, 2, 0, 0);
    send_group(2'b11, 2'b11, 0, 1, 2, 3, 1, 2);
    send_group(2'b11, 2'b01, 4, 3, 0, 6, 0, 0);

    // forwarding inside the group, then slot 1 wins the map
    send_group(2'b11, 2'b11, 5, 1, 4, 5, 5, 5);
    send_group(2'b11, 2'b00, 0, 5, 5, 0, 5, 1);

    // drain slot 0 list with no commits
    k = 0;
    while (alloc_cnt[0] < FLIST_DEPTH) begin
      send_group(2'b01, 2'b01, 1 + (k % 30), k % 32, 5, 0, 0, 0);
      k++;
    end
    set_group(2'b01, 2'b01, 7, 7, 1, 0, 0, 0);
    repeat (3) begin
      @(negedge i_clk);
      check_ready(o_ready, 1'b0, "o_ready with empty list");
    end
    cmt_credit = 1;   // one slot 0 commit frees its old id
    wait_accept();

    // ------------------------------------------------------------
    // random groups with random commits
    // ------------------------------------------------------------
    cmt_rand_en = 1'b1;
    for (int n = 0; n < N_RAND; n++) begin
      stim_seed = lcg_step(stim_seed);
      r = stim_seed;
      if (r[31:29] == 3'b000) begin
        i_front_valid = 1'b0;   // idle cycle
        @(posedge i_clk);
        #2;
      end else begin
        send_group({r[0] | r[1], r[2] | r[3]}, {r[4] | r[5], r[6] | r[7]},
                   int'(r[10:8]), int'(r[13:11]), int'(r[18:14]),
                   int'(r[21:19]), int'(r[24:22]), int'(r[28:25]));
      end
    end
    repeat (4) @(posedge i_clk);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hw/rename_pkg.sv
hw/rename_group_if.sv
hw/rename_freelist.sv
hw/rename_commit_release.sv
hw/rename_map_table.sv
hw/rename_group_bypass.sv
hw/rename_unit.sv
tb/rename_unit_sva.sv
tb/tb_rename_unit.sv

/* run.sh */
#!/bin/sh
# build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
  --top-module tb_rename_unit --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
  exit 0
else
  exit 1
fi
